// ==== logic/flash_boot_pkg.sv ====
// shared widths and types for the flash boot subsystem
// spi read opcode and the reader state encoding
package flash_boot_pkg;

    // boot ram holds 2**RAM_ADDR_BITS words
    localparam int RAM_ADDR_BITS = 8;

    // byte address into the serial flash, 16 MB space
    typedef logic [23:0] flash_addr_t;

    // data word as assembled by the reader, byte 0 in bits 7:0
    typedef logic [31:0] word_t;

    // cpu word offset into the flash user region
    typedef logic [17:0] cpu_offset_t;

    // word index into the boot ram
    typedef logic [RAM_ADDR_BITS-1:0] ram_addr_t;

    // standard slow read, no dummy cycles
    localparam logic [7:0] READ_CMD = 8'h03;

    // reader fsm
    // IDLE  cs high, waiting for a request
    // CMD   shifting out opcode and 24-bit address
    // DATA  shifting in one 32-bit word
    // HOLD  cs held low between sequential words
    typedef enum logic [1:0] {
        IDLE,
        CMD,
        DATA,
        HOLD
    } spi_state_t;

endpackage

// ==== logic/flash_read_if.sv ====
// word read channel from the dma to the spi reader
// requester drives valid/cont/addr, server answers with ready/rdata
`timescale 1ns/1ps

interface flash_read_if;
    import flash_boot_pkg::*;

    // request side, held steady until ready
    logic        valid;
    logic        cont;
    flash_addr_t addr;

    // one-cycle completion pulse, rdata held until the next word
    logic        ready;
    word_t       rdata;

    modport requester (
        output valid, cont, addr,
        input  ready, rdata
    );

    modport server (
        input  valid, cont, addr,
        output ready, rdata
    );

endinterface

// ==== logic/spi_flash_reader.sv ====
// spi master reading 32-bit words from a serial flash
// read command plus address, then bytes packed lsb first
// cs stays low between words when the requester asks to continue
`timescale 1ns/1ps

module spi_flash_reader (
    input  logic            clk,
    input  logic            reset,
    flash_read_if.server    rd,
    output logic            sck,
    output logic            csn,
    output logic            mosi,
    input  logic            miso
);
    import flash_boot_pkg::*;

    spi_state_t  state;

    // counts bit times within the command phase and within a data word
    logic [4:0]  bit_cnt;

    // command/address out during CMD, data in during DATA
    word_t       shreg;

    logic        start;
    logic        fall_edge;
    logic        last_bit;

    // ignore the request in the cycle of our own ready pulse,
    // the requester only updates valid/addr on that edge
    assign start = (state == IDLE) && rd.valid && !rd.ready;

    // sck high now means the next clk edge drives it low
    assign fall_edge = sck;
    assign last_bit  = fall_edge && (bit_cnt == 5'd31);

    // mosi only carries opcode and address, quiet otherwise
    assign mosi = (state == CMD) ? shreg[31] : 1'b0;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= IDLE;
            csn     <= 1'b1;
            sck     <= 1'b0;
            bit_cnt <= '0;
            rd.ready <= 1'b0;
        end else begin
            rd.ready <= 1'b0;

            case (state)
                IDLE: begin
                    if (start) begin
                        csn     <= 1'b0;
                        bit_cnt <= '0;
                        state   <= CMD;
                    end
                end

                CMD: begin
                    sck <= !sck;
                    // advance on the falling sck edge
                    if (fall_edge) begin
                        bit_cnt <= bit_cnt + 5'd1;
                        if (last_bit) begin
                            state <= DATA;
                        end
                    end
                end

                DATA: begin
                    sck <= !sck;
                    if (fall_edge) begin
                        bit_cnt <= bit_cnt + 5'd1;
                    end
                    if (last_bit) begin
                        rd.ready <= 1'b1;
                        // cont decides whether the burst stays open
                        if (rd.cont) begin
                            state <= HOLD;
                        end else begin
                            csn   <= 1'b1;
                            state <= IDLE;
                        end
                    end
                end

                HOLD: begin
                    // sequential word needs no new command
                    if (!rd.ready) begin
                        if (rd.valid) begin
                            bit_cnt <= '0;
                            state   <= DATA;
                        end else if (!rd.cont) begin
                            csn   <= 1'b1;
                            state <= IDLE;
                        end
                    end
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // shift path, no reset needed on payload
    always_ff @(posedge clk) begin
        if (start) begin
            shreg <= {READ_CMD, rd.addr};
        end else if (state == CMD && fall_edge) begin
            shreg <= {shreg[30:0], 1'b0};
        end else if (state == DATA && !sck) begin
            // miso sampled as sck rises
            shreg <= {shreg[30:0], miso};
        end

        // first byte received lands in the low byte
        if (state == DATA && last_bit) begin
            rd.rdata <= {shreg[7:0], shreg[15:8], shreg[23:16], shreg[31:24]};
        end
    end

endmodule

// ==== logic/flash_dma.sv ====
// boot copy engine from flash into the boot ram
// then cpu word reads from the flash user region over a four-phase handshake
// both share one flash reader, the boot copy owns it while busy
`timescale 1ns/1ps

module flash_dma #(
    parameter flash_boot_pkg::flash_addr_t LOAD_BASE  = 24'h100000,
    parameter integer                      LOAD_WORDS = 64,
    parameter flash_boot_pkg::flash_addr_t USER_BASE  = 24'h100000
) (
    input  logic                        clk,
    input  logic                        reset,

    // cpu read port
    input  logic                        cpu_req,
    input  flash_boot_pkg::cpu_offset_t cpu_addr,
    output logic                        cpu_ack,
    output flash_boot_pkg::word_t       cpu_rdata,

    // high while the boot copy runs, keeps the cpu off
    output logic                        boot_busy,

    // boot ram write side
    output logic                        ram_we,
    output flash_boot_pkg::ram_addr_t   ram_waddr,
    output flash_boot_pkg::word_t       ram_wdata,

    flash_read_if.requester             rd
);
    import flash_boot_pkg::*;

    // index of the final boot word, unused when nothing is copied
    localparam ram_addr_t LAST_WORD     = ram_addr_t'(LOAD_WORDS - 1);
    localparam logic      BOOT_ON_RESET = (LOAD_WORDS > 0);

    // boot copy state
    flash_addr_t boot_addr;
    ram_addr_t   boot_count;
    logic        boot_last;

    // cpu read state
    logic        cpu_pend;
    flash_addr_t cpu_read_addr;
    logic        cpu_start;

    // final word of the burst arrives
    assign boot_last = boot_busy && rd.ready && (boot_count == LAST_WORD);

    // new cpu read only once the previous ack has dropped
    assign cpu_start = !boot_busy && cpu_req && !cpu_ack && !cpu_pend;

    always_ff @(posedge clk) begin
        if (reset) begin
            boot_busy  <= BOOT_ON_RESET;
            boot_count <= '0;
            boot_addr  <= LOAD_BASE;
        end else if (boot_busy && rd.ready) begin
            // one word per ready, addresses run sequentially
            boot_count <= boot_count + 1'b1;
            boot_addr  <= boot_addr + 24'd4;
            if (boot_last) begin
                // hand the reader over to the cpu
                boot_busy <= 1'b0;
            end
        end
    end

    // ack side of the cpu handshake
    always_ff @(posedge clk) begin
        if (reset) begin
            cpu_pend <= 1'b0;
            cpu_ack  <= 1'b0;
        end else begin
            if (cpu_start) begin
                cpu_pend <= 1'b1;
            end else if (cpu_pend && rd.ready) begin
                cpu_pend <= 1'b0;
                cpu_ack  <= 1'b1;
            end

            // ack stays up for as long as the cpu holds req
            if (cpu_ack && !cpu_req) begin
                cpu_ack <= 1'b0;
            end
        end
    end

    // cpu offset is in words, flash is byte addressed
    always_ff @(posedge clk) begin
        if (cpu_start) begin
            cpu_read_addr <= USER_BASE + flash_addr_t'({cpu_addr, 2'b00});
        end
    end

    // reader request mux
    // boot burst keeps valid and cont up until the last word is in,
    // then both fall together which closes the burst
    assign rd.valid = boot_busy || cpu_pend;
    assign rd.cont  = boot_busy;
    assign rd.addr  = boot_busy ? boot_addr : cpu_read_addr;

    // ram write straight off the ready pulse
    assign ram_we    = boot_busy && rd.ready;
    assign ram_waddr = boot_count;
    assign ram_wdata = rd.rdata;

    // reader holds rdata until its next word, no new read while ack is high
    assign cpu_rdata = rd.rdata;

endmodule

// ==== logic/boot_ram.sv ====
// boot ram, one write port for the dma
// one registered read port for the cpu
`timescale 1ns/1ps

module boot_ram #(
    parameter int DEPTH_BITS = flash_boot_pkg::RAM_ADDR_BITS
) (
    input  logic                      clk,

    // write side, from the boot copy
    input  logic                      we,
    input  flash_boot_pkg::ram_addr_t waddr,
    input  flash_boot_pkg::word_t     wdata,

    // read side, data one cycle after the address
    input  flash_boot_pkg::ram_addr_t raddr,
    output flash_boot_pkg::word_t     rdata
);
    import flash_boot_pkg::*;

    localparam int DEPTH = 2 ** DEPTH_BITS;

    // contents come from flash, no reset
    word_t mem [DEPTH];

    // only the low index bits select a word when the ram is shallower
    logic [DEPTH_BITS-1:0] widx;
    logic [DEPTH_BITS-1:0] ridx;

    assign widx = waddr[DEPTH_BITS-1:0];
    assign ridx = raddr[DEPTH_BITS-1:0];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[widx] <= wdata;
        end
    end

    // registered read, maps onto block ram
    always_ff @(posedge clk) begin
        rdata <= mem[ridx];
    end

endmodule

// ==== logic/flash_boot_top.sv ====
// flash boot subsystem top level
// dma and spi reader joined by the flash read channel, plus the boot ram
`timescale 1ns/1ps

module flash_boot_top #(
    parameter flash_boot_pkg::flash_addr_t LOAD_BASE  = 24'h100000,
    parameter integer                      LOAD_WORDS = 64,
    parameter flash_boot_pkg::flash_addr_t USER_BASE  = 24'h100000
) (
    input  logic                        clk,
    input  logic                        reset,

    // cpu flash read, four-phase req/ack
    input  logic                        cpu_req,
    input  flash_boot_pkg::cpu_offset_t cpu_addr,
    output logic                        cpu_ack,
    output flash_boot_pkg::word_t       cpu_rdata,
    output logic                        boot_busy,

    // cpu boot ram read
    input  flash_boot_pkg::ram_addr_t   ram_raddr,
    output flash_boot_pkg::word_t       ram_rdata,

    // spi flash pins
    output logic                        flash_sck,
    output logic                        flash_csn,
    output logic                        flash_mosi,
    input  logic                        flash_miso
);
    import flash_boot_pkg::*;

    // boot copy into the ram
    logic      ram_we;
    ram_addr_t ram_waddr;
    word_t     ram_wdata;

    flash_read_if rd_bus ();

    spi_flash_reader reader_inst (
        .clk   (clk),
        .reset (reset),
        .rd    (rd_bus.server),
        .sck   (flash_sck),
        .csn   (flash_csn),
        .mosi  (flash_mosi),
        .miso  (flash_miso)
    );

    flash_dma #(
        .LOAD_BASE  (LOAD_BASE),
        .LOAD_WORDS (LOAD_WORDS),
        .USER_BASE  (USER_BASE)
    ) dma_inst (
        .clk       (clk),
        .reset     (reset),
        .cpu_req   (cpu_req),
        .cpu_addr  (cpu_addr),
        .cpu_ack   (cpu_ack),
        .cpu_rdata (cpu_rdata),
        .boot_busy (boot_busy),
        .ram_we    (ram_we),
        .ram_waddr (ram_waddr),
        .ram_wdata (ram_wdata),
        .rd        (rd_bus.requester)
    );

    boot_ram #(
        .DEPTH_BITS (RAM_ADDR_BITS)
    ) ram_inst (
        .clk   (clk),
        .we    (ram_we),
        .waddr (ram_waddr),
        .wdata (ram_wdata),
        .raddr (ram_raddr),
        .rdata (ram_rdata)
    );

endmodule

// ==== sim/spi_flash_model.sv ====
// behavioral serial flash for the boot testbench
// answers the 0x03 read command with a pattern computed from the byte address
// bytes go out msb first, address auto-increments while cs stays low
`timescale 1ns/1ps

module spi_flash_model (
    input  logic sck,
    input  logic csn,
    input  logic mosi,
    output logic miso,
    // sticky, set when an opcode other than the read command arrives
    output logic bad_cmd
);
    import flash_boot_pkg::*;

    logic [31:0] cmd_sr    = '0;
    int          in_cnt    = 0;
    int          bit_idx   = 7;
    logic        streaming = 1'b0;
    flash_addr_t rd_addr   = '0;
    logic [7:0]  cur_byte  = '0;
    logic        next_bit  = 1'b0;
    logic        miso_r    = 1'b0;
    logic        bad_cmd_r = 1'b0;

    assign miso    = miso_r;
    assign bad_cmd = bad_cmd_r;

    // flash contents, a mix of every address bit
    function automatic logic [7:0] pattern_byte(input flash_addr_t a);
        return {a[4:0], a[7:5]} ^ a[15:8] ^ {a[19:16], a[23:20]} ^ 8'h5a;
    endfunction

    // mosi sampled on rising sck, cs high restarts the command
    always @(posedge sck or posedge csn) begin
        if (csn) begin
            in_cnt    = 0;
            bit_idx   = 7;
            streaming = 1'b0;
        end else if (!streaming) begin
            cmd_sr = {cmd_sr[30:0], mosi};
            in_cnt = in_cnt + 1;
            if (in_cnt == 32) begin
                if (cmd_sr[31:24] == READ_CMD) begin
                    streaming = 1'b1;
                    rd_addr   = cmd_sr[23:0];
                    bit_idx   = 7;
                end else begin
                    bad_cmd_r = 1'b1;
                end
            end
        end else begin
            // previous bit was taken, step to the next one
            if (bit_idx == 0) begin
                bit_idx = 7;
                rd_addr = rd_addr + 24'd1;
            end else begin
                bit_idx = bit_idx - 1;
            end
        end
        cur_byte = pattern_byte(rd_addr);
        next_bit = cur_byte[bit_idx];
    end

    // data changes on falling sck, master samples on the next rise
    always @(negedge sck) begin
        if (!csn && streaming) begin
            miso_r <= next_bit;
        end
    end

endmodule

// ==== sim/flash_boot_chk.sv ====
// concurrent assertions on the cpu handshake, the spi pins and the boot flag
// bound into the flash boot top level
`timescale 1ns/1ps

module flash_boot_chk (
    input logic clk,
    input logic reset,
    input logic cpu_req,
    input logic cpu_ack,
    input logic boot_busy,
    input logic flash_sck,
    input logic flash_csn
);

    // ack drops only once the cpu has let go of req
    ack_release: assert property (@(posedge clk) disable iff (reset)
        $fell(cpu_ack) |-> !$past(cpu_req))
        else $error("cpu_ack fell while cpu_req was still high");

    // spi clock idles low whenever the flash is deselected
    sck_idle: assert property (@(posedge clk) disable iff (reset)
        flash_csn |-> !flash_sck)
        else $error("flash_sck high while flash_csn is high");

    // boot copy runs once per reset
    busy_once: assert property (@(posedge clk) disable iff (reset)
        !boot_busy |=> !boot_busy)
        else $error("boot_busy rose again after the boot copy ended");

    // cpu is kept off the flash during the boot copy
    no_ack_in_boot: assert property (@(posedge clk) disable iff (reset)
        boot_busy |-> !cpu_ack)
        else $error("cpu_ack high while boot_busy is high");

endmodule

bind flash_boot_top flash_boot_chk chk_inst (
    .clk       (clk),
    .reset     (reset),
    .cpu_req   (cpu_req),
    .cpu_ack   (cpu_ack),
    .boot_busy (boot_busy),
    .flash_sck (flash_sck),
    .flash_csn (flash_csn)
);

// ==== sim/flash_boot_tb.sv ====
// flash boot testbench
// clock, reset, boot and cpu read stimulus, reference model, compare and watchdog
`timescale 1ns/1ps

module flash_boot_tb;
    import flash_boot_pkg::*;

    localparam flash_addr_t LOAD_BASE  = 24'h100000;
    localparam int          LOAD_WORDS = 64;
    localparam flash_addr_t USER_BASE  = 24'h100000;
    localparam int          CPU_READS  = 40;
    // words times 80 bit times times 20 ns per bit, doubled for margin
    localparam int          WATCHDOG_NS = (LOAD_WORDS + CPU_READS) * 80 * 20 * 2;

    logic        clk;
    logic        reset;
    logic        cpu_req;
    cpu_offset_t cpu_addr;
    logic        cpu_ack;
    word_t       cpu_rdata;
    logic        boot_busy;
    ram_addr_t   ram_raddr;
    word_t       ram_rdata;
    logic        flash_sck;
    logic        flash_csn;
    logic        flash_mosi;
    logic        flash_miso;
    logic        model_bad_cmd;

    int          word_errors  = 0;
    int          flag_errors  = 0;
    int          other_errors = 0;

    // offsets of requests still waiting for their ack
    cpu_offset_t offset_q[$];
    cpu_offset_t done_offset;
    logic        ack_q = 1'b0;

    flash_boot_top #(
        .LOAD_BASE  (LOAD_BASE),
        .LOAD_WORDS (LOAD_WORDS),
        .USER_BASE  (USER_BASE)
    ) flash_boot_top_inst (
        .clk        (clk),
        .reset      (reset),
        .cpu_req    (cpu_req),
        .cpu_addr   (cpu_addr),
        .cpu_ack    (cpu_ack),
        .cpu_rdata  (cpu_rdata),
        .boot_busy  (boot_busy),
        .ram_raddr  (ram_raddr),
        .ram_rdata  (ram_rdata),
        .flash_sck  (flash_sck),
        .flash_csn  (flash_csn),
        .flash_mosi (flash_mosi),
        .flash_miso (flash_miso)
    );

    spi_flash_model flash_model_inst (
        .sck     (flash_sck),
        .csn     (flash_csn),
        .mosi    (flash_mosi),
        .miso    (flash_miso),
        .bad_cmd (model_bad_cmd)
    );

    // expected flash contents
    function automatic logic [7:0] flash_byte(input flash_addr_t a);
        return {a[4:0], a[7:5]} ^ a[15:8] ^ {a[19:16], a[23:20]} ^ 8'h5a;
    endfunction

    // four bytes, lowest address in bits 7:0
    function automatic word_t flash_word(input flash_addr_t a);
        return {flash_byte(a + 24'd3), flash_byte(a + 24'd2),
                flash_byte(a + 24'd1), flash_byte(a)};
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            word_errors++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            flag_errors++;
            $display("** Error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // polls on falling edges, gives up after limit cycles
    task automatic wait_for_ack(input logic level, input int limit, output logic seen);
        int n;
        n = 0;
        while (cpu_ack !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        seen = (cpu_ack === level);
    endtask

    // one four-phase read, req held for hold extra cycles after the ack
    task automatic cpu_read(input cpu_offset_t offset, input int hold, input int limit);
        logic seen;
        offset_q.push_back(offset);
        cpu_addr = offset;
        cpu_req  = 1'b1;
        @(negedge clk);
        wait_for_ack(1'b1, limit, seen);
        if (!seen) begin
            other_errors++;
            $display("no cpu_ack within %0d cycles for offset %h", limit, offset);
            void'(offset_q.pop_front());
        end
        repeat (hold) begin
            @(negedge clk);
            check_flag("cpu_ack held while cpu_req high", 1'b1, cpu_ack);
        end
        cpu_req = 1'b0;
        @(negedge clk);
        wait_for_ack(1'b0, 16, seen);
        if (!seen) begin
            other_errors++;
            $display("cpu_ack stayed high after cpu_req dropped, offset %h", offset);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // compares every cpu read as its ack rises
    always @(negedge clk) begin
        if (cpu_ack === 1'b1 && !ack_q) begin
            if (offset_q.size() == 0) begin
                other_errors++;
                $display("cpu_ack rose with no request outstanding");
            end else begin
                done_offset = offset_q.pop_front();
                check_word($sformatf("cpu read offset %h", done_offset),
                           flash_word(USER_BASE + flash_addr_t'(4 * done_offset)),
                           cpu_rdata);
                check_flag("boot_busy low at cpu_ack", 1'b0, boot_busy);
            end
        end
        ack_q = (cpu_ack === 1'b1);
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        void'($urandom(87077));
        reset     = 1'b1;
        cpu_req   = 1'b0;
        cpu_addr  = '0;
        ram_raddr = '0;
        repeat (8) @(negedge clk);
        check_flag("reset cpu_ack", 1'b0, cpu_ack);
        check_flag("reset flash_csn", 1'b1, flash_csn);
        check_flag("reset flash_sck", 1'b0, flash_sck);
        check_flag("reset boot_busy", 1'b1, boot_busy);
        reset = 1'b0;
        @(negedge clk);
        check_flag("boot_busy after reset", 1'b1, boot_busy);

        // request raised during the boot copy, answered once it ends
        cpu_read(cpu_offset_t'($urandom), 2, LOAD_WORDS * 140 + 400);
        check_flag("boot copy done", 1'b0, boot_busy);

        // boot ram readback, data one cycle after the address
        for (int i = 0; i < LOAD_WORDS; i++) begin
            ram_raddr = ram_addr_t'(i);
            @(negedge clk);
            check_word($sformatf("boot ram word %0d", i),
                       flash_word(LOAD_BASE + flash_addr_t'(4 * i)), ram_rdata);
        end

        for (int i = 0; i < CPU_READS; i++) begin
            cpu_read(cpu_offset_t'($urandom), $urandom_range(7, 0), 400);
        end

        check_flag("flash read opcode error", 1'b0, model_bad_cmd);
        $display("error count: %0d word, %0d flag, %0d other",
                 word_errors, flag_errors, other_errors);
        if (word_errors + flag_errors + other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
logic/flash_boot_pkg.sv
logic/flash_read_if.sv
logic/spi_flash_reader.sv
logic/flash_dma.sv
logic/boot_ram.sv
logic/flash_boot_top.sv
sim/spi_flash_model.sv
sim/flash_boot_chk.sv
sim/flash_boot_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the flash boot testbench with verilator
# fails when the log reports a failure or the run stops early

cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module flash_boot_tb \
    -f compile.f -o flash_boot_sim \
    && ./obj_dir/flash_boot_sim > sim.log 2>&1 \
    || echo "simulation did not complete" >> sim.log
cat sim.log
grep -q "Test FAILED" sim.log && exit 1
grep -q "Test OK" sim.log || exit 1
exit 0
